// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the vlane_driver testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_vlane_driver \
    -f src.f -Mdir obj_dir -o vsim
./obj_dir/vsim 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"

// ==== src.f ====
+incdir+.
vlane_pkg.sv
vrf_addr_counter.sv
vlane_decode.sv
vlane_sequencer.sv
vrf_write_unit.sv
vlane_driver.sv
tb_vlane_driver.sv

// ==== tb_vlane_model.svh ====
`ifndef TB_VLANE_MODEL_SVH
`define TB_VLANE_MODEL_SVH

////////////////////////////////////////
// Random source

logic [31:0] lcg_state = 32'hc8993aab;

// LCG step, result taken from the upper bits
function automatic int rand_below(input int n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'(lcg_state[31:8] % n);
endfunction

////////////////////////////////////////
// Reference model

// Elements per lane, rounded up
function automatic int lane_length(input int vl);
    return (vl + VLANE_NUM - 1) / VLANE_NUM;
endfunction

// Word address of element n when elements pack into 32-bit words
function automatic logic [ADDR_W-1:0] stride_addr(input logic [ADDR_W-1:0] start, input int n,
                                                  input vlane_pkg::ew_e ew);
    int per_word;
    case (ew)
        vlane_pkg::EW_BYTE: per_word = 4;
        vlane_pkg::EW_HALF: per_word = 2;
        default:            per_word = 1;
    endcase
    return start + ADDR_W'(n / per_word);
endfunction

// Byte lanes written by normal beat j
function automatic logic [vlane_pkg::BWEN_W-1:0] beat_bwen(input vlane_pkg::ew_e ew, input int j);
    logic [vlane_pkg::BWEN_W-1:0] bwen;
    bwen = '0;
    case (ew)
        vlane_pkg::EW_BYTE: bwen[j % 4] = 1'b1;
        vlane_pkg::EW_HALF: bwen[2 * (j % 2) +: 2] = 2'b11;
        default:            bwen = '1;
    endcase
    return bwen;
endfunction

////////////////////////////////////////
// Compare tasks

task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp_v,
                          input logic [ADDR_W-1:0] act_v);
    if (act_v !== exp_v) begin
        $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp_v, act_v);
        stop_on_error("Address mismatch");
    end
endtask

task automatic check_bwen(input string name, input logic [vlane_pkg::BWEN_W-1:0] exp_v,
                          input logic [vlane_pkg::BWEN_W-1:0] act_v);
    if (act_v !== exp_v) begin
        $display("CHECK FAILED %s: expected %b, actual %b", name, exp_v, act_v);
        stop_on_error("Byte enable mismatch");
    end
endtask

task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
        $display("CHECK FAILED %s: expected %b, actual %b", name, exp_v, act_v);
        stop_on_error("Control level mismatch");
    end
endtask

task automatic check_count(input string name, input int exp_v, input int act_v);
    if (act_v != exp_v) begin
        $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp_v, act_v);
        stop_on_error("Count mismatch");
    end
endtask

`endif

// ==== tb_vlane_driver.sv ====
`timescale 1ns/100ps

module tb_vlane_driver;

    localparam int MEM_DEPTH       = 512;
    localparam int VLANE_NUM       = 8;
    localparam int MAX_VL_PER_LANE = 256;
    localparam int ADDR_W = $clog2(MEM_DEPTH);
    localparam int VL_W   = $clog2(VLANE_NUM * MAX_VL_PER_LANE) + 1;
    localparam int ID_W   = $clog2(MAX_VL_PER_LANE);
    localparam int VM_W   = $clog2(MAX_VL_PER_LANE);

    localparam int N_INST    = 20;
    localparam int DELAY_MAX = 20;
    localparam int VL_MAX    = 256;                  // Up to 32 elements per lane
    localparam int LOAD_MAX  = 48;
    localparam int TIMEOUT_CYCLES =
        N_INST * (DELAY_MAX + VL_MAX / VLANE_NUM + LOAD_MAX + 10);

    logic                  clk_i;
    logic                  rst_i;
    logic                  start_i;
    vlane_pkg::inst_type_e inst_type_i;
    logic [VL_W-1:0]       vl_i;
    vlane_pkg::ew_e        vsew_i;
    vlane_pkg::ew_e        wdata_width_i;
    logic [ID_W-1:0]       inst_delay_i;
    logic [ADDR_W-1:0]     vrf_starting_waddr_i;
    logic [vlane_pkg::N_RPORTS-1:0][ADDR_W-1:0] vrf_starting_raddr_i;
    logic                  load_valid_i;
    logic                  load_last_i;
    logic                  ready_o;
    logic [vlane_pkg::N_RPORTS-1:0][ADDR_W-1:0] vrf_raddr_o;
    logic [ADDR_W-1:0]     vrf_waddr_o;
    logic [vlane_pkg::BWEN_W-1:0] vrf_bwen_o;
    logic [VM_W-1:0]       vmrf_addr_o;
    logic                  vmrf_wen_o;
    logic                  store_data_valid_o;
    logic                  store_load_index_valid_o;
    logic                  ready_for_load_o;
    int                    cycle_cnt = 0;

    vlane_driver #(
        .MEM_DEPTH       (MEM_DEPTH),
        .VLANE_NUM       (VLANE_NUM),
        .MAX_VL_PER_LANE (MAX_VL_PER_LANE)
    ) u_dut (.*);

    always #2 clk_i = ~clk_i;

    task automatic stop_on_error(input string reason);
        $display("Verification failed");
        $fatal(1, "%s", reason);
    endtask

    `include "tb_vlane_model.svh"

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) stop_on_error("Timeout, the DUT never returned to idle");
    end

    task automatic check_idle(input string name);
        check_flag({name, " ready"}, 1'b1, ready_o);
        check_flag({name, " vmrf_wen"}, 1'b0, vmrf_wen_o);
        check_bwen({name, " bwen"}, '0, vrf_bwen_o);
        check_flag({name, " store_data_valid"}, 1'b0, store_data_valid_o);
        check_flag({name, " index_valid"}, 1'b0, store_load_index_valid_o);
        check_flag({name, " ready_for_load"}, 1'b0, ready_for_load_o);
        check_count({name, " vmrf_addr"}, 0, int'(vmrf_addr_o));
    endtask

    ////////////////////////////////////////
    // One instruction, start to idle

    task automatic run_instruction(input int idx);
        vlane_pkg::inst_type_e itype;
        vlane_pkg::ew_e        vsew;
        vlane_pkg::ew_e        wdw;
        logic [ADDR_W-1:0]     waddr;
        logic [vlane_pkg::N_RPORTS-1:0][ADDR_W-1:0] raddr;
        int    sel, vl, rl, delay, load_len, exp_len, k, beats;
        logic  lv, is_read, is_beat;
        string tag;

        sel = (idx < 6) ? idx : rand_below(13);            // First six cover every type
        case (sel)
            0, 6, 7, 8: itype = vlane_pkg::NORMAL;
            1, 9:       itype = vlane_pkg::STORE;
            2:          itype = vlane_pkg::INDEXED_STORE;
            3, 10:      itype = vlane_pkg::LOAD;
            4:          itype = vlane_pkg::INDEXED_LOAD;
            5:          itype = vlane_pkg::inst_type_e'(3'd1);
            11:         itype = vlane_pkg::inst_type_e'(3'd6);
            default:    itype = vlane_pkg::inst_type_e'(3'd7);
        endcase
        vl       = 1 + rand_below(VL_MAX);
        rl       = lane_length(vl);
        delay    = rand_below(DELAY_MAX + 1);
        vsew     = vlane_pkg::ew_e'(2'(1 + rand_below(3)));
        wdw      = vlane_pkg::ew_e'(2'(1 + rand_below(3)));
        waddr    = ADDR_W'(rand_below(MEM_DEPTH));
        for (int p = 0; p < vlane_pkg::N_RPORTS; p++) raddr[p] = ADDR_W'(rand_below(MEM_DEPTH));
        load_len = 1 + rand_below(LOAD_MAX);
        is_read  = itype inside {vlane_pkg::STORE, vlane_pkg::INDEXED_STORE, vlane_pkg::INDEXED_LOAD};

        @(posedge clk_i);
        start_i              <= 1'b1;
        inst_type_i          <= itype;
        vl_i                 <= VL_W'(vl);
        vsew_i               <= vsew;
        wdata_width_i        <= wdw;
        inst_delay_i         <= ID_W'(delay);
        vrf_starting_waddr_i <= waddr;
        vrf_starting_raddr_i <= raddr;
        case (itype)
            vlane_pkg::NORMAL: exp_len = delay + rl + 1;
            vlane_pkg::LOAD:   exp_len = load_len;
            default:           exp_len = is_read ? rl : 0;
        endcase

        @(posedge clk_i);                                  // Start accepted here
        start_i              <= 1'b0;
        vl_i                 <= VL_W'(rand_below(VL_MAX));    // Decode must hold its copy
        inst_delay_i         <= ID_W'(rand_below(DELAY_MAX + 1));
        vsew_i               <= vlane_pkg::ew_e'(2'(1 + rand_below(3)));
        wdata_width_i        <= vlane_pkg::ew_e'(2'(1 + rand_below(3)));
        vrf_starting_waddr_i <= ~waddr;
        vrf_starting_raddr_i <= ~raddr;
        k     = 0;
        beats = 0;
        while (1) begin
            if (itype == vlane_pkg::LOAD && k < load_len) begin
                lv = (rand_below(4) != 0);
                load_last_i <= (k == load_len - 1);
            end else begin
                lv = (rand_below(2) == 1);                 // Noise outside load mode
                load_last_i <= (rand_below(2) == 1);
            end
            load_valid_i <= lv;
            @(negedge clk_i);
            if (ready_o) break;
            if (k >= exp_len) stop_on_error($sformatf("Instruction %0d stayed busy too long", idx));
            tag = $sformatf("inst %0d cycle %0d", idx, k);
            check_flag({tag, " ready_for_load"}, itype == vlane_pkg::LOAD, ready_for_load_o);
            check_flag({tag, " store_data_valid"},
                       itype inside {vlane_pkg::STORE, vlane_pkg::INDEXED_STORE}, store_data_valid_o);
            check_flag({tag, " index_valid"},
                       itype inside {vlane_pkg::INDEXED_STORE, vlane_pkg::INDEXED_LOAD},
                       store_load_index_valid_o);
            if (itype != vlane_pkg::LOAD) begin
                for (int p = 0; p < vlane_pkg::N_RPORTS; p++)
                    check_addr($sformatf("%s raddr%0d", tag, p), stride_addr(raddr[p], k, vsew),
                               vrf_raddr_o[p]);
            end
            is_beat = (itype == vlane_pkg::NORMAL) ? (k > delay) : (itype == vlane_pkg::LOAD) && lv;
            check_flag({tag, " vmrf_wen"}, is_beat && itype == vlane_pkg::NORMAL, vmrf_wen_o);
            if (!is_beat) begin
                check_bwen({tag, " bwen"}, '0, vrf_bwen_o);
            end else if (itype == vlane_pkg::NORMAL) begin
                check_addr({tag, " waddr"}, stride_addr(waddr, beats, wdw), vrf_waddr_o);
                check_bwen({tag, " bwen"}, beat_bwen(wdw, beats), vrf_bwen_o);
                check_count({tag, " vmrf_addr"}, beats, int'(vmrf_addr_o));
                beats++;
            end else begin
                check_addr({tag, " waddr"}, stride_addr(waddr, beats, vlane_pkg::EW_WORD),
                           vrf_waddr_o);
                check_bwen({tag, " bwen"}, '1, vrf_bwen_o);
                beats++;
            end
            @(posedge clk_i);
            k++;
        end

        check_count($sformatf("inst %0d busy cycles", idx), exp_len, k);
        check_idle($sformatf("inst %0d first idle", idx));
        @(posedge clk_i);
        @(negedge clk_i);
        check_idle($sformatf("inst %0d second idle", idx));
    endtask

    initial begin
        clk_i                = 1'b0;
        rst_i                = 1'b0;
        start_i              = 1'b0;
        inst_type_i          = vlane_pkg::NORMAL;
        vl_i                 = '0;
        vsew_i               = vlane_pkg::EW_WORD;
        wdata_width_i        = vlane_pkg::EW_WORD;
        inst_delay_i         = '0;
        vrf_starting_waddr_i = '0;
        vrf_starting_raddr_i = '0;
        load_valid_i         = 1'b0;
        load_last_i          = 1'b0;
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b1;
        @(negedge clk_i);
        check_idle("after reset");
        for (int i = 0; i < N_INST; i++) run_instruction(i);
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== vlane_decode.sv ====
`timescale 1ns/100ps

module vlane_decode #(
    parameter int MEM_DEPTH       = 512,
    parameter int VLANE_NUM       = 8,
    parameter int MAX_VL_PER_LANE = 256,
    localparam int ADDR_W = $clog2(MEM_DEPTH),
    localparam int VL_W   = $clog2(VLANE_NUM * MAX_VL_PER_LANE) + 1,
    localparam int RL_W   = $clog2(MAX_VL_PER_LANE) + 1,
    localparam int ID_W   = $clog2(MAX_VL_PER_LANE)
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  start_i,
    input  logic                  ready_i,
    input  logic                  done_i,
    input  vlane_pkg::inst_type_e inst_type_i,
    input  logic [VL_W-1:0]       vl_i,
    input  vlane_pkg::ew_e        vsew_i,
    input  vlane_pkg::ew_e        wdata_width_i,
    input  logic [ID_W-1:0]       inst_delay_i,
    input  logic [ADDR_W-1:0]     waddr_start_i,
    input  logic [vlane_pkg::N_RPORTS-1:0][ADDR_W-1:0] raddr_start_i,
    output vlane_pkg::mode_e      mode_o,
    output logic [RL_W-1:0]       read_limit_o,
    output logic [ID_W-1:0]       inst_delay_o,
    output vlane_pkg::ew_e        vsew_o,
    output vlane_pkg::ew_e        wdata_width_o,
    output logic [ADDR_W-1:0]     waddr_start_o,
    output logic [vlane_pkg::N_RPORTS-1:0][ADDR_W-1:0] raddr_start_o,
    output logic                  store_data_valid_o,
    output logic                  index_valid_o
);

    vlane_pkg::mode_e  next_mode;
    logic              accept;
    logic [RL_W-1:0]   lane_len;

    assign accept   = start_i && ready_i && (next_mode != vlane_pkg::MODE_IDLE);
    assign lane_len = RL_W'(vl_i / VLANE_NUM) + RL_W'((vl_i % VLANE_NUM) != 0);   // ceil

    always_comb begin
        case (inst_type_i)
            vlane_pkg::NORMAL:        next_mode = vlane_pkg::MODE_NORMAL;
            vlane_pkg::STORE,
            vlane_pkg::INDEXED_STORE,
            vlane_pkg::INDEXED_LOAD:  next_mode = vlane_pkg::MODE_READ;
            vlane_pkg::LOAD:          next_mode = vlane_pkg::MODE_LOAD;
            default:                  next_mode = vlane_pkg::MODE_IDLE;   // Illegal type
        endcase
    end

    ////////////////////////////////////////
    // Mode and valid levels

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            mode_o             <= vlane_pkg::MODE_IDLE;
            store_data_valid_o <= 1'b0;
            index_valid_o      <= 1'b0;
        end else if (accept) begin
            mode_o             <= next_mode;
            store_data_valid_o <= inst_type_i inside {vlane_pkg::STORE, vlane_pkg::INDEXED_STORE};
            index_valid_o      <= inst_type_i inside {vlane_pkg::INDEXED_STORE,
                                                      vlane_pkg::INDEXED_LOAD};
        end else if (done_i) begin
            mode_o             <= vlane_pkg::MODE_IDLE;
            store_data_valid_o <= 1'b0;
            index_valid_o      <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            read_limit_o  <= lane_len;
            inst_delay_o  <= inst_delay_i;
            vsew_o        <= vsew_i;
            wdata_width_o <= wdata_width_i;
        end
    end

    // Counters load in idle and take the live addresses on the accept edge
    assign waddr_start_o = waddr_start_i;
    assign raddr_start_o = raddr_start_i;

    // A new instruction is only taken in idle
    a_accept_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        accept |-> mode_o == vlane_pkg::MODE_IDLE);

endmodule

// ==== vlane_driver.sv ====
`timescale 1ns/100ps

module vlane_driver #(
    parameter int MEM_DEPTH       = 512,
    parameter int VLANE_NUM       = 8,
    parameter int MAX_VL_PER_LANE = 256,
    localparam int ADDR_W = $clog2(MEM_DEPTH),
    localparam int VL_W   = $clog2(VLANE_NUM * MAX_VL_PER_LANE) + 1,
    localparam int RL_W   = $clog2(MAX_VL_PER_LANE) + 1,
    localparam int ID_W   = $clog2(MAX_VL_PER_LANE),
    localparam int VM_W   = $clog2(MAX_VL_PER_LANE)
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          start_i,
    input  vlane_pkg::inst_type_e         inst_type_i,
    input  logic [VL_W-1:0]               vl_i,
    input  vlane_pkg::ew_e                vsew_i,
    input  vlane_pkg::ew_e                wdata_width_i,
    input  logic [ID_W-1:0]               inst_delay_i,
    input  logic [ADDR_W-1:0]             vrf_starting_waddr_i,
    input  logic [vlane_pkg::N_RPORTS-1:0][ADDR_W-1:0] vrf_starting_raddr_i,
    input  logic                          load_valid_i,
    input  logic                          load_last_i,
    output logic                          ready_o,
    output logic [vlane_pkg::N_RPORTS-1:0][ADDR_W-1:0] vrf_raddr_o,
    output logic [ADDR_W-1:0]             vrf_waddr_o,
    output logic [vlane_pkg::BWEN_W-1:0]  vrf_bwen_o,
    output logic [VM_W-1:0]               vmrf_addr_o,
    output logic                          vmrf_wen_o,
    output logic                          store_data_valid_o,
    output logic                          store_load_index_valid_o,
    output logic                          ready_for_load_o
);

    vlane_pkg::mode_e  mode;
    vlane_pkg::ew_e    vsew;
    vlane_pkg::ew_e    wdata_width;
    logic [RL_W-1:0]   read_limit;
    logic [ID_W-1:0]   inst_delay;
    logic [ADDR_W-1:0] waddr_start;
    logic [vlane_pkg::N_RPORTS-1:0][ADDR_W-1:0] raddr_start;
    logic              done;
    logic              raddr_load;
    logic              raddr_en;
    logic              write_active;

    ////////////////////////////////////////
    // Decode and execute

    vlane_decode #(
        .MEM_DEPTH          (MEM_DEPTH),
        .VLANE_NUM          (VLANE_NUM),
        .MAX_VL_PER_LANE    (MAX_VL_PER_LANE)
    ) u_decode (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .start_i            (start_i),
        .ready_i            (ready_o),
        .done_i             (done),
        .inst_type_i        (inst_type_i),
        .vl_i               (vl_i),
        .vsew_i             (vsew_i),
        .wdata_width_i      (wdata_width_i),
        .inst_delay_i       (inst_delay_i),
        .waddr_start_i      (vrf_starting_waddr_i),
        .raddr_start_i      (vrf_starting_raddr_i),
        .mode_o             (mode),
        .read_limit_o       (read_limit),
        .inst_delay_o       (inst_delay),
        .vsew_o             (vsew),
        .wdata_width_o      (wdata_width),
        .waddr_start_o      (waddr_start),
        .raddr_start_o      (raddr_start),
        .store_data_valid_o (store_data_valid_o),
        .index_valid_o      (store_load_index_valid_o)
    );

    vlane_sequencer #(
        .MAX_VL_PER_LANE (MAX_VL_PER_LANE)
    ) u_sequencer (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .mode_i          (mode),
        .read_limit_i    (read_limit),
        .inst_delay_i    (inst_delay),
        .load_last_i     (load_last_i),
        .ready_o         (ready_o),
        .done_o          (done),
        .raddr_load_o    (raddr_load),
        .raddr_en_o      (raddr_en),
        .write_active_o  (write_active)
    );

    ////////////////////////////////////////
    // Operand read addresses, one per port

    for (genvar i = 0; i < vlane_pkg::N_RPORTS; i++) begin : g_raddr
        vrf_addr_counter #(
            .MEM_DEPTH    (MEM_DEPTH)
        ) u_raddr_cnt (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .start_addr_i (raddr_start[i]),
            .load_i       (raddr_load),
            .en_i         (raddr_en),
            .ew_i         (vsew),
            .addr_o       (vrf_raddr_o[i])
        );
    end

    vrf_write_unit #(
        .MEM_DEPTH        (MEM_DEPTH),
        .MAX_VL_PER_LANE  (MAX_VL_PER_LANE)
    ) u_write (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .mode_i           (mode),
        .write_active_i   (write_active),
        .load_valid_i     (load_valid_i),
        .waddr_start_i    (waddr_start),
        .wdata_width_i    (wdata_width),
        .vrf_waddr_o      (vrf_waddr_o),
        .vrf_bwen_o       (vrf_bwen_o),
        .vmrf_addr_o      (vmrf_addr_o),
        .vmrf_wen_o       (vmrf_wen_o),
        .ready_for_load_o (ready_for_load_o)
    );

endmodule

// ==== vlane_pkg.sv ====
package vlane_pkg;

    ////////////////////////////////////////
    // Instruction and width encodings

    // Values 1, 6 and 7 are illegal
    typedef enum logic [2:0] {
        NORMAL        = 3'd0,
        STORE         = 3'd2,
        INDEXED_STORE = 3'd3,
        LOAD          = 3'd4,
        INDEXED_LOAD  = 3'd5
    } inst_type_e;

    // Shared by vsew and wdata_width, 0 is not a width
    typedef enum logic [1:0] {
        EW_BYTE = 2'd1,
        EW_HALF = 2'd2,
        EW_WORD = 2'd3
    } ew_e;

    ////////////////////////////////////////
    // Sequencer modes

    typedef enum logic [1:0] {
        MODE_IDLE,
        MODE_NORMAL,
        MODE_READ,                            // Store, indexed store, indexed load
        MODE_LOAD
    } mode_e;

    ////////////////////////////////////////
    // Fixed constants

    localparam int BWEN_W   = 4;              // Bytes per VRF word
    localparam int N_RPORTS = 3;              // vs1, vs2, vs3

endpackage

// ==== vlane_sequencer.sv ====
`timescale 1ns/100ps

module vlane_sequencer #(
    parameter int MAX_VL_PER_LANE = 256,
    localparam int RL_W  = $clog2(MAX_VL_PER_LANE) + 1,
    localparam int ID_W  = $clog2(MAX_VL_PER_LANE),
    localparam int CNT_W = $clog2(MAX_VL_PER_LANE) + 2
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  vlane_pkg::mode_e mode_i,
    input  logic [RL_W-1:0]  read_limit_i,
    input  logic [ID_W-1:0]  inst_delay_i,
    input  logic             load_last_i,
    output logic             ready_o,
    output logic             done_o,
    output logic             raddr_load_o,
    output logic             raddr_en_o,
    output logic             write_active_o
);

    logic [CNT_W-1:0] main_cnt;
    logic [CNT_W-1:0] end_cnt;                // Last cycle of a normal instruction
    logic [CNT_W-1:0] delay_cnt;

    assign delay_cnt = CNT_W'(inst_delay_i);
    assign end_cnt   = delay_cnt + CNT_W'(read_limit_i);

    ////////////////////////////////////////
    // Main counter

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            main_cnt <= '0;
        end else if (mode_i == vlane_pkg::MODE_IDLE || done_o) begin
            main_cnt <= '0;                   // Zero again on the first idle cycle
        end else begin
            main_cnt <= main_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Per mode control

    always_comb begin
        ready_o        = (mode_i == vlane_pkg::MODE_IDLE);
        raddr_load_o   = (mode_i == vlane_pkg::MODE_IDLE);
        raddr_en_o     = 1'b0;
        write_active_o = 1'b0;
        done_o         = 1'b0;
        case (mode_i)
            vlane_pkg::MODE_NORMAL: begin
                raddr_en_o     = 1'b1;
                // Results land inst_delay cycles behind the operand reads
                write_active_o = (main_cnt > delay_cnt) && (main_cnt <= end_cnt);
                done_o         = (main_cnt == end_cnt);
            end
            vlane_pkg::MODE_READ: begin
                raddr_en_o = 1'b1;
                done_o     = (main_cnt + 1'b1 >= CNT_W'(read_limit_i));
            end
            vlane_pkg::MODE_LOAD: begin
                done_o = load_last_i;         // Memory side decides the length
            end
            default: begin
                done_o = 1'b0;
            end
        endcase
    end

    // Decode drops back to idle one edge after done
    a_done_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        done_o |=> ready_o);

endmodule

// ==== vrf_addr_counter.sv ====
`timescale 1ns/100ps

module vrf_addr_counter #(
    parameter int MEM_DEPTH = 512,
    localparam int ADDR_W = $clog2(MEM_DEPTH)
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic [ADDR_W-1:0] start_addr_i,
    input  logic              load_i,
    input  logic              en_i,
    input  vlane_pkg::ew_e    ew_i,
    output logic [ADDR_W-1:0] addr_o
);

    logic [1:0] sub_cnt;                      // Elements consumed in current word

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            addr_o  <= '0;
            sub_cnt <= '0;
        end else if (load_i) begin
            addr_o  <= start_addr_i;
            sub_cnt <= '0;
        end else if (en_i) begin
            case (ew_i)
                vlane_pkg::EW_BYTE: begin
                    sub_cnt <= sub_cnt + 2'd1;
                    if (sub_cnt == 2'd3) addr_o <= addr_o + 1'b1;   // Four bytes per word
                end
                vlane_pkg::EW_HALF: begin
                    sub_cnt <= {1'b0, ~sub_cnt[0]};
                    if (sub_cnt[0]) addr_o <= addr_o + 1'b1;        // Two halves per word
                end
                default: begin
                    addr_o <= addr_o + 1'b1;
                end
            endcase
        end
    end

    // A step with no element width means decode passed on a bad field
    a_ew_legal: assert property (@(posedge clk_i) disable iff (!rst_i)
        en_i |-> ew_i != 2'd0);

endmodule

// ==== vrf_write_unit.sv ====
`timescale 1ns/100ps

module vrf_write_unit #(
    parameter int MEM_DEPTH       = 512,
    parameter int MAX_VL_PER_LANE = 256,
    localparam int ADDR_W = $clog2(MEM_DEPTH),
    localparam int VM_W   = $clog2(MAX_VL_PER_LANE)
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  vlane_pkg::mode_e              mode_i,
    input  logic                          write_active_i,
    input  logic                          load_valid_i,
    input  logic [ADDR_W-1:0]             waddr_start_i,
    input  vlane_pkg::ew_e                wdata_width_i,
    output logic [ADDR_W-1:0]             vrf_waddr_o,
    output logic [vlane_pkg::BWEN_W-1:0]  vrf_bwen_o,
    output logic [VM_W-1:0]               vmrf_addr_o,
    output logic                          vmrf_wen_o,
    output logic                          ready_for_load_o
);

    logic                         load_beat;
    logic                         idle;
    vlane_pkg::ew_e               ew_wr;
    logic [VM_W-1:0]              vmrf_cnt;
    logic [vlane_pkg::BWEN_W-1:0] rot_bwen;

    assign idle             = (mode_i == vlane_pkg::MODE_IDLE);
    assign ready_for_load_o = (mode_i == vlane_pkg::MODE_LOAD);
    assign load_beat        = ready_for_load_o && load_valid_i;
    // Loads fill whole words
    assign ew_wr            = ready_for_load_o ? vlane_pkg::EW_WORD : wdata_width_i;

    vrf_addr_counter #(
        .MEM_DEPTH    (MEM_DEPTH)
    ) u_waddr_cnt (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .start_addr_i (waddr_start_i),
        .load_i       (idle),
        .en_i         (write_active_i || load_beat),
        .ew_i         (ew_wr),
        .addr_o       (vrf_waddr_o)
    );

    ////////////////////////////////////////
    // Mask address and byte enables

    always_ff @(posedge clk_i) begin
        if (!rst_i || idle) begin
            vmrf_cnt <= '0;                   // Restart per instruction
        end else if (write_active_i) begin
            vmrf_cnt <= vmrf_cnt + 1'b1;
        end
    end

    // Beat count low bits pick the byte lane
    always_comb begin
        case (wdata_width_i)
            vlane_pkg::EW_BYTE: rot_bwen = 4'b0001 << vmrf_cnt[1:0];
            vlane_pkg::EW_HALF: rot_bwen = vmrf_cnt[0] ? 4'b1100 : 4'b0011;
            default:            rot_bwen = 4'b1111;
        endcase
    end

    assign vrf_bwen_o  = write_active_i ? rot_bwen : {vlane_pkg::BWEN_W{load_beat}};
    assign vmrf_addr_o = idle ? '0 : vmrf_cnt;   // Zero from the first idle cycle
    assign vmrf_wen_o  = write_active_i;

    // Result beats come only from a normal instruction
    a_beat_normal: assert property (@(posedge clk_i) disable iff (!rst_i)
        write_active_i |-> mode_i == vlane_pkg::MODE_NORMAL);

endmodule
